//--- src/emuPkg.sv
// Host side of the co-emulation link: slot numbering and frame layouts
// Stimulus slots 6 and 7 do not exist, result slots 4 to 7 read as zero
package emuPkg;

    typedef logic [7:0]  hostByte;
    typedef logic [2:0]  slotIndex;
    typedef logic [15:0] hostMemAddr;   // Two slots, high byte first

    localparam int NUM_STIM_SLOTS   = 6;
    localparam int NUM_RESULT_SLOTS = 4;

    // Stimulus slots
    localparam slotIndex SLOT_CTRL      = 3'd0;
    localparam slotIndex SLOT_KEY       = 3'd1;
    localparam slotIndex SLOT_MEMCTRL   = 3'd2;
    localparam slotIndex SLOT_MEMADDRHI = 3'd3;
    localparam slotIndex SLOT_MEMADDRLO = 3'd4;
    localparam slotIndex SLOT_MEMDATA   = 3'd5;

    // Result slots
    localparam int RES_DISPLAY = 0;
    localparam int RES_KEYREG  = 1;
    localparam int RES_KEYCTRL = 2;
    localparam int RES_MEMDATA = 3;

    localparam int CTRL_KBD_STROBE  = 4;
    localparam int CTRL_DISPLAY_ACK = 5;
    localparam int MEMCTRL_ENABLE   = 0;
    localparam int MEMCTRL_WRITE    = 1;

    typedef struct packed {
        logic       kbdStrobe;
        logic       displayAck;
        hostByte    keyCode;
        logic       memHostEnable;
        logic       memHostWrite;
        hostMemAddr memHostAddr;
        hostByte    memHostData;
    } stimFrame;

    typedef struct packed {
        hostByte displayReg;
        hostByte keyReg;
        hostByte keyCtrl;
        hostByte memReadData;
    } captureFrame;

endpackage

//--- src/busPkg.sv
// CPU bus view of the system: widths, PIA map and decoded accesses
// Only D010 to D012 are decoded, D013 falls through to memory
package busPkg;

    typedef logic [15:0] busAddr;
    typedef logic [7:0]  busData;

    // PIA register map
    localparam busAddr PIA_KBD_REG = 16'hD010;
    localparam busAddr PIA_KBD_CTL = 16'hD011;
    localparam busAddr PIA_DSP_REG = 16'hD012;
    localparam busAddr PIA_DSP_CTL = 16'hD013;   // Reserved, served by memory

    localparam int KBD_READY_BIT = 7;

    typedef struct packed {
        logic kbdRegRead;     // CPU reads key register
        logic dspRegWrite;    // CPU writes display register
        logic dspAddressed;   // Display register on the bus, either direction
    } pioAccess;

    typedef enum logic {
        ready,
        waitAck
    } displayState;

endpackage

//--- src/hostTransactor.sv
// Host slot transactor, load has priority over get
// Idle cycles write one stimulus slot and read one result slot at hostAddr,
// so the host must resend the slot value whenever it reads
`timescale 1ns/10ps

module hostTransactor
(
    input  logic                 clk_dut,
    input  logic                 reset,
    input  emuPkg::hostByte      hostDataIn,
    input  emuPkg::slotIndex     hostAddr,
    input  logic                 load,
    input  logic                 get,
    input  emuPkg::captureFrame  results,
    output emuPkg::hostByte      hostDataOut,
    output emuPkg::stimFrame     stim
);

    emuPkg::hostByte stimSlots [emuPkg::NUM_STIM_SLOTS];
    emuPkg::hostByte resultSlots [emuPkg::NUM_RESULT_SLOTS];

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < emuPkg::NUM_STIM_SLOTS; i++)
            begin
                stimSlots[i] <= '0;
            end
            for (int i = 0; i < emuPkg::NUM_RESULT_SLOTS; i++)
            begin
                resultSlots[i] <= '0;
            end
            hostDataOut <= '0;
            stim        <= '0;
        end
        else if (load)
        begin
            stim.kbdStrobe     <= stimSlots[emuPkg::SLOT_CTRL][emuPkg::CTRL_KBD_STROBE];
            stim.displayAck    <= stimSlots[emuPkg::SLOT_CTRL][emuPkg::CTRL_DISPLAY_ACK];
            stim.keyCode       <= stimSlots[emuPkg::SLOT_KEY];
            stim.memHostEnable <= stimSlots[emuPkg::SLOT_MEMCTRL][emuPkg::MEMCTRL_ENABLE];
            stim.memHostWrite  <= stimSlots[emuPkg::SLOT_MEMCTRL][emuPkg::MEMCTRL_WRITE];
            stim.memHostAddr   <= {stimSlots[emuPkg::SLOT_MEMADDRHI],
                                   stimSlots[emuPkg::SLOT_MEMADDRLO]};
            stim.memHostData   <= stimSlots[emuPkg::SLOT_MEMDATA];
        end
        else if (get)
        begin
            resultSlots[emuPkg::RES_DISPLAY] <= results.displayReg;
            resultSlots[emuPkg::RES_KEYREG]  <= results.keyReg;
            resultSlots[emuPkg::RES_KEYCTRL] <= results.keyCtrl;
            resultSlots[emuPkg::RES_MEMDATA] <= results.memReadData;
        end
        else
        begin
            if (hostAddr <= emuPkg::SLOT_MEMDATA)   // Slots 6 and 7 dropped
            begin
                stimSlots[hostAddr] <= hostDataIn;
            end
            if (hostAddr < emuPkg::NUM_RESULT_SLOTS)
            begin
                hostDataOut <= resultSlots[hostAddr[1:0]];
            end
            else
            begin
                hostDataOut <= '0;
            end
        end
    end

endmodule

//--- src/busDecoder.sv
// PIA address decode and CPU read bus multiplexer
// Read selects follow the address of the previous cycle, matching the
// one-cycle memory read latency
`timescale 1ns/10ps

module busDecoder
(
    input  logic             clk_dut,
    input  logic             reset,
    input  busPkg::busAddr   cpuAddr,
    input  logic             cpuWrite,
    input  busPkg::busData   keyReg,
    input  busPkg::busData   keyCtrl,
    input  busPkg::busData   displayReg,
    input  busPkg::busData   memReadData,
    output busPkg::pioAccess access,
    output busPkg::busData   cpuDataIn
);

    logic kbdRegSel;
    logic kbdCtlSel;
    logic dspRegSel;

    always_comb
    begin
        access.kbdRegRead   = (cpuAddr == busPkg::PIA_KBD_REG) && !cpuWrite;
        access.dspRegWrite  = (cpuAddr == busPkg::PIA_DSP_REG) && cpuWrite;
        access.dspAddressed = (cpuAddr == busPkg::PIA_DSP_REG);
    end

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            kbdRegSel <= 1'b0;
            kbdCtlSel <= 1'b0;
            dspRegSel <= 1'b0;
        end
        else
        begin
            kbdRegSel <= (cpuAddr == busPkg::PIA_KBD_REG);
            kbdCtlSel <= (cpuAddr == busPkg::PIA_KBD_CTL);
            dspRegSel <= (cpuAddr == busPkg::PIA_DSP_REG);
        end
    end

    always_comb
    begin
        if (kbdRegSel)
            cpuDataIn = keyReg;
        else if (kbdCtlSel)
            cpuDataIn = keyCtrl;
        else if (dspRegSel)
            cpuDataIn = displayReg;
        else
            cpuDataIn = memReadData;    // Everything else, D013 included
    end

endmodule

//--- src/keyboardPort.sv
// Keyboard PIA port with single-shot strobe
// Key and ready bit land on the third edge after the strobe rises
// A strobe held high sets the ready bit once only
`timescale 1ns/10ps

module keyboardPort
(
    input  logic           clk_dut,
    input  logic           reset,
    input  logic           kbdStrobe,
    input  busPkg::busData keyCode,
    input  logic           kbdRegRead,
    output busPkg::busData keyReg,
    output busPkg::busData keyCtrl
);

    logic strobeSync0;
    logic strobeSync1;
    logic setReady;
    logic keyReady;

    // Rising edge of the strobe, one cycle wide
    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            strobeSync0 <= 1'b0;
            strobeSync1 <= 1'b0;
            setReady    <= 1'b0;
        end
        else
        begin
            strobeSync0 <= kbdStrobe;
            strobeSync1 <= strobeSync0;
            setReady    <= strobeSync0 && !strobeSync1;
        end
    end

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            keyReg   <= '0;
            keyReady <= 1'b0;
        end
        else if (setReady)      // New key wins over a pending clear
        begin
            keyReg   <= keyCode;
            keyReady <= 1'b1;
        end
        else if (kbdRegRead)
        begin
            keyReady <= 1'b0;
        end
    end

    always_comb
    begin
        keyCtrl = '0;
        keyCtrl[busPkg::KBD_READY_BIT] = keyReady;
    end

endmodule

//--- src/displayPort.sv
// Display PIA register with host acknowledge
// Writes are taken only in ready; the register clears once ack drops
// while the CPU is off the display address
`timescale 1ns/10ps

module displayPort
(
    input  logic           clk_dut,
    input  logic           reset,
    input  logic           dspRegWrite,
    input  logic           dspAddressed,
    input  logic           displayAck,
    input  busPkg::busData cpuDataOut,
    output busPkg::busData displayReg
);

    busPkg::displayState state;

    always_ff @(posedge clk_dut or posedge reset)
    begin
        if (reset)
        begin
            state      <= busPkg::ready;
            displayReg <= '0;
        end
        else
        begin
            case (state)
                busPkg::ready:
                begin
                    if (dspRegWrite)
                    begin
                        displayReg <= cpuDataOut;
                    end
                    else if (displayAck)
                    begin
                        state <= busPkg::waitAck;   // Host has taken the character
                    end
                end
                busPkg::waitAck:
                begin
                    if (!dspAddressed && !displayAck)
                    begin
                        displayReg <= '0;
                        state      <= busPkg::ready;
                    end
                end
                default:
                begin
                    state <= busPkg::ready;
                end
            endcase
        end
    end

endmodule

//--- src/embeddedMemory.sv
// Byte memory shared by host and CPU, host wins when hostEnable is high
// Content is undefined until loaded; reads are registered, one cycle
`timescale 1ns/10ps

module embeddedMemory
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic                  clk_dut,
    input  logic                  hostEnable,
    input  logic                  hostWrite,
    input  logic [ADDR_WIDTH-1:0] hostAddr,
    input  busPkg::busData        hostData,
    input  logic [ADDR_WIDTH-1:0] cpuAddr,
    input  logic                  cpuWrite,
    input  busPkg::busData        cpuDataOut,
    output busPkg::busData        readData
);

    busPkg::busData mem [2**ADDR_WIDTH];

    logic [ADDR_WIDTH-1:0] selAddr;
    logic                  selWrite;
    busPkg::busData        selData;

    always_comb
    begin
        if (hostEnable)
        begin
            selAddr  = hostAddr;
            selWrite = hostWrite;
            selData  = hostData;
        end
        else
        begin
            selAddr  = cpuAddr;
            selWrite = cpuWrite;
            selData  = cpuDataOut;
        end
    end

    always_ff @(posedge clk_dut)
    begin
        if (selWrite)
            mem[selAddr] <= selData;
        else
            readData <= mem[selAddr];   // Holds last read during writes
    end

endmodule

//--- src/emuWrapper.sv
// Co-emulation top for the 6502 I/O side, the CPU bus is on ports
// ADDR_WIDTH sets memory depth and must not exceed 16
// One clock, asynchronous active-high reset
`timescale 1ns/10ps

module emuWrapper
#(
    parameter int ADDR_WIDTH = 16
)
(
    input  logic             clk_dut,
    input  logic             reset,
    input  emuPkg::hostByte  hostDataIn,
    input  emuPkg::slotIndex hostAddr,
    input  logic             load,
    input  logic             get,
    output emuPkg::hostByte  hostDataOut,
    input  busPkg::busAddr   cpuAddr,
    input  logic             cpuWrite,
    input  busPkg::busData   cpuDataOut,
    output busPkg::busData   cpuDataIn
);

    emuPkg::stimFrame    stim;
    emuPkg::captureFrame results;
    busPkg::pioAccess    access;
    busPkg::busData      keyReg;
    busPkg::busData      keyCtrl;
    busPkg::busData      displayReg;
    busPkg::busData      memReadData;

    assign results = '{displayReg:  displayReg,
                       keyReg:      keyReg,
                       keyCtrl:     keyCtrl,
                       memReadData: memReadData};

    hostTransactor uHostTransactor
    (
        .clk_dut     (clk_dut),
        .reset       (reset),
        .hostDataIn  (hostDataIn),
        .hostAddr    (hostAddr),
        .load        (load),
        .get         (get),
        .results     (results),
        .hostDataOut (hostDataOut),
        .stim        (stim)
    );

    busDecoder uBusDecoder
    (
        .clk_dut     (clk_dut),
        .reset       (reset),
        .cpuAddr     (cpuAddr),
        .cpuWrite    (cpuWrite),
        .keyReg      (keyReg),
        .keyCtrl     (keyCtrl),
        .displayReg  (displayReg),
        .memReadData (memReadData),
        .access      (access),
        .cpuDataIn   (cpuDataIn)
    );

    keyboardPort uKeyboardPort
    (
        .clk_dut    (clk_dut),
        .reset      (reset),
        .kbdStrobe  (stim.kbdStrobe),
        .keyCode    (stim.keyCode),
        .kbdRegRead (access.kbdRegRead),
        .keyReg     (keyReg),
        .keyCtrl    (keyCtrl)
    );

    displayPort uDisplayPort
    (
        .clk_dut      (clk_dut),
        .reset        (reset),
        .dspRegWrite  (access.dspRegWrite),
        .dspAddressed (access.dspAddressed),
        .displayAck   (stim.displayAck),
        .cpuDataOut   (cpuDataOut),
        .displayReg   (displayReg)
    );

    embeddedMemory #(.ADDR_WIDTH(ADDR_WIDTH)) uEmbeddedMemory
    (
        .clk_dut    (clk_dut),
        .hostEnable (stim.memHostEnable),
        .hostWrite  (stim.memHostWrite),
        .hostAddr   (stim.memHostAddr[ADDR_WIDTH-1:0]),
        .hostData   (stim.memHostData),
        .cpuAddr    (cpuAddr[ADDR_WIDTH-1:0]),
        .cpuWrite   (cpuWrite),
        .cpuDataOut (cpuDataOut),
        .readData   (memReadData)
    );

endmodule

//--- dv/tbTasks.svh
// Host slot tasks and typed compare tasks, included in the testbench module
// Idle host cycles rewrite the addressed slot, so hostDataIn always carries its shadow

task automatic writeSlot(input emuPkg::slotIndex idx, input emuPkg::hostByte value);
    @(negedge clk_dut);
    slotShadow[idx] = value;
    hostAddr        = idx;
    hostDataIn      = value;
endtask

task automatic loadStim();
    @(negedge clk_dut);
    load = 1'b1;
    @(negedge clk_dut);
    load = 1'b0;
endtask

// One idle edge before get lets a registered memory read settle
task automatic captureResults();
    @(negedge clk_dut);
    get = 1'b1;
    @(negedge clk_dut);
    get = 1'b0;
endtask

task automatic readSlot(input emuPkg::slotIndex idx, output emuPkg::hostByte value);
    @(negedge clk_dut);
    hostAddr   = idx;
    hostDataIn = slotShadow[idx];   // Resend, the idle cycle writes it back
    @(negedge clk_dut);
    value = hostDataOut;
endtask

task automatic checkHostByte(input string testName, input emuPkg::hostByte expected,
                             input emuPkg::hostByte actual);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("MISMATCH %s: expected %02h, actual %02h", testName, expected, actual);
    end
endtask

task automatic checkBusData(input string testName, input busPkg::busData expected,
                            input busPkg::busData actual);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("MISMATCH %s: expected %02h, actual %02h", testName, expected, actual);
    end
endtask

//--- dv/tbEmuWrapper.sv
// Testbench for emuWrapper that plays both the host and the 6502 bus master
// Random memory addresses are steered off the PIA block D010 to D013
`timescale 1ns/10ps

module tbEmuWrapper;

    localparam int ADDR_WIDTH = 16;
    localparam int MAX_CYCLES = 20000;
    localparam int NUM_RANDOM = 32;
    localparam busPkg::busAddr PARK_ADDR = 16'h0200;   // Parked reads hit plain memory

    logic             clk_dut = 1'b0;
    logic             reset;
    emuPkg::hostByte  hostDataIn;
    emuPkg::slotIndex hostAddr;
    logic             load;
    logic             get;
    emuPkg::hostByte  hostDataOut;
    busPkg::busAddr   cpuAddr;
    logic             cpuWrite;
    busPkg::busData   cpuDataOut;
    busPkg::busData   cpuDataIn;

    int seed       = 32'h289d68b4;
    int errorCount = 0;
    int checkCount = 0;
    int cycleCount = 0;

    emuPkg::hostByte slotShadow [8];
    busPkg::busData  modelMem [65536];
    busPkg::busData  modelKeyReg;
    busPkg::busData  modelKeyCtrl;
    busPkg::busData  modelDisplayReg;
    busPkg::busAddr  hostWritten [$];
    busPkg::busAddr  busWritten [$];
    busPkg::busAddr  addr;
    busPkg::busData  data;
    emuPkg::hostByte value;

    // Read issued on the bus and staged one edge for the compare
    logic           readPending = 1'b0;
    string          readName;
    busPkg::busData readExpected;
    logic           checkValid = 1'b0;
    string          checkName;
    busPkg::busData checkExpected;

    emuWrapper #(.ADDR_WIDTH(ADDR_WIDTH)) DUT (.*);

    `include "tbTasks.svh"

    always #50 clk_dut = ~clk_dut;

    // Priority goes key register, key control, display register, memory
    function automatic busPkg::busData expectedReadData(input busPkg::busAddr readAddr);
        if (readAddr == busPkg::PIA_KBD_REG)
            return modelKeyReg;
        if (readAddr == busPkg::PIA_KBD_CTL)
            return modelKeyCtrl;
        if (readAddr == busPkg::PIA_DSP_REG)
            return modelDisplayReg;
        return modelMem[readAddr];              // D013 too
    endfunction

    function automatic busPkg::busAddr randomAddr();
        busPkg::busAddr newAddr;
        newAddr = 16'($random(seed));
        if (newAddr[15:2] == 14'h3404)
            newAddr = newAddr ^ 16'h0100;
        return newAddr;
    endfunction

    task automatic loadMemByte(input busPkg::busAddr memAddr, input busPkg::busData memData);
        writeSlot(emuPkg::SLOT_MEMADDRHI, memAddr[15:8]);
        writeSlot(emuPkg::SLOT_MEMADDRLO, memAddr[7:0]);
        writeSlot(emuPkg::SLOT_MEMDATA, memData);
        writeSlot(emuPkg::SLOT_MEMCTRL, 8'h03);    // Enable and write
        loadStim();
        modelMem[memAddr] = memData;
    endtask

    task automatic fetchMemByte(input busPkg::busAddr memAddr, output emuPkg::hostByte memData);
        writeSlot(emuPkg::SLOT_MEMADDRHI, memAddr[15:8]);
        writeSlot(emuPkg::SLOT_MEMADDRLO, memAddr[7:0]);
        writeSlot(emuPkg::SLOT_MEMCTRL, 8'h01);
        loadStim();
        captureResults();
        readSlot(3'(emuPkg::RES_MEMDATA), memData);
    endtask

    task automatic checkResultSlot(input string testName, input int idx,
                                   input emuPkg::hostByte expected);
        emuPkg::hostByte actual;
        readSlot(3'(idx), actual);
        checkHostByte(testName, expected, actual);
    endtask

    task automatic busWrite(input busPkg::busAddr wrAddr, input busPkg::busData wrData);
        @(negedge clk_dut);
        cpuAddr     = wrAddr;
        cpuWrite    = 1'b1;
        cpuDataOut  = wrData;
        readPending = 1'b0;
        if (wrAddr != busPkg::PIA_DSP_REG)
            modelMem[wrAddr] = wrData;          // Display model follows the FSM in the tests
    endtask

    task automatic busRead(input string testName, input busPkg::busAddr rdAddr);
        @(negedge clk_dut);
        cpuAddr      = rdAddr;
        cpuWrite     = 1'b0;
        readPending  = 1'b1;
        readName     = testName;
        readExpected = expectedReadData(rdAddr);
        if (rdAddr == busPkg::PIA_KBD_REG)
            modelKeyCtrl = '0;                  // Key read drops ready
    endtask

    task automatic parkBus();
        @(negedge clk_dut);
        cpuAddr     = PARK_ADDR;
        cpuWrite    = 1'b0;
        readPending = 1'b0;
    endtask

    always @(posedge clk_dut)
    begin
        checkValid    <= readPending;
        checkName     <= readName;
        checkExpected <= readExpected;
    end

    always @(negedge clk_dut)
    begin
        if (checkValid)
            checkBusData(checkName, checkExpected, cpuDataIn);
    end

    always @(posedge clk_dut)
    begin
        cycleCount++;
        if (cycleCount >= MAX_CYCLES)
        begin
            $display("Timeout: tests did not complete within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        reset           = 1'b1;
        hostDataIn      = '0;
        hostAddr        = '0;
        load            = 1'b0;
        get             = 1'b0;
        cpuAddr         = PARK_ADDR;
        cpuWrite        = 1'b0;
        cpuDataOut      = '0;
        modelKeyReg     = '0;
        modelKeyCtrl    = '0;
        modelDisplayReg = '0;
        foreach (slotShadow[i])
            slotShadow[i] = '0;
        repeat (8) @(negedge clk_dut);
        reset = 1'b0;

        for (int i = 0; i < 4; i++)
            checkResultSlot("resetSlot", i, 8'h00);
        busRead("resetKbdReg", busPkg::PIA_KBD_REG);
        busRead("resetKbdCtl", busPkg::PIA_KBD_CTL);
        busRead("resetDspReg", busPkg::PIA_DSP_REG);
        parkBus();

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            addr = randomAddr();
            loadMemByte(addr, 8'($random(seed)));
            hostWritten.push_back(addr);
        end
        foreach (hostWritten[i])
        begin
            fetchMemByte(hostWritten[i], value);
            checkHostByte("hostMem", modelMem[hostWritten[i]], value);
        end

        writeSlot(emuPkg::SLOT_MEMCTRL, 8'h00);     // CPU owns memory
        loadStim();
        for (int i = 0; i < 8; i++)
        begin
            addr = randomAddr();
            busWrite(addr, 8'($random(seed)));
            busRead("cpuMem", addr);
            busWritten.push_back(addr);
        end
        parkBus();
        foreach (busWritten[i])
        begin
            fetchMemByte(busWritten[i], value);
            checkHostByte("cpuMemByHost", modelMem[busWritten[i]], value);
        end

        data = 8'($random(seed));
        writeSlot(emuPkg::SLOT_KEY, data);
        writeSlot(emuPkg::SLOT_CTRL, 8'h10);        // Strobe up
        loadStim();
        repeat (3) @(negedge clk_dut);
        captureResults();
        modelKeyReg  = data;
        modelKeyCtrl = 8'h80;
        checkResultSlot("kbdSetKey", emuPkg::RES_KEYREG, modelKeyReg);
        checkResultSlot("kbdSetCtl", emuPkg::RES_KEYCTRL, modelKeyCtrl);
        busRead("kbdReadKey", busPkg::PIA_KBD_REG);
        busRead("kbdCtlCleared", busPkg::PIA_KBD_CTL);
        parkBus();
        captureResults();
        checkResultSlot("kbdClearKey", emuPkg::RES_KEYREG, modelKeyReg);
        checkResultSlot("kbdClearCtl", emuPkg::RES_KEYCTRL, 8'h00);
        writeSlot(emuPkg::SLOT_KEY, ~data);         // Strobe still high so no new edge
        loadStim();
        repeat (3) @(negedge clk_dut);
        captureResults();
        checkResultSlot("kbdHeldKey", emuPkg::RES_KEYREG, modelKeyReg);
        checkResultSlot("kbdHeldCtl", emuPkg::RES_KEYCTRL, 8'h00);
        writeSlot(emuPkg::SLOT_CTRL, 8'h00);
        loadStim();

        data = 8'($random(seed));
        busWrite(busPkg::PIA_DSP_REG, data);
        modelDisplayReg = data;
        busRead("dspWrite", busPkg::PIA_DSP_REG);
        parkBus();
        captureResults();
        checkResultSlot("dspCapture", emuPkg::RES_DISPLAY, modelDisplayReg);
        writeSlot(emuPkg::SLOT_CTRL, 8'h20);        // Ack moves the FSM to waitAck
        loadStim();
        busWrite(busPkg::PIA_DSP_REG, ~data);
        busRead("dspWriteIgnored", busPkg::PIA_DSP_REG);
        parkBus();
        writeSlot(emuPkg::SLOT_CTRL, 8'h00);
        loadStim();
        modelDisplayReg = '0;
        busRead("dspCleared", busPkg::PIA_DSP_REG);
        parkBus();
        captureResults();
        checkResultSlot("dspClearCapture", emuPkg::RES_DISPLAY, 8'h00);

        writeSlot(emuPkg::SLOT_MEMCTRL, 8'h00);     // Memory back to the CPU
        loadStim();
        data = 8'($random(seed));
        busWrite(busPkg::PIA_DSP_REG, data);
        modelDisplayReg = data;
        busWrite(busPkg::PIA_DSP_CTL, ~data);       // Plain memory byte
        busRead("muxKbdReg", busPkg::PIA_KBD_REG);
        busRead("muxKbdCtl", busPkg::PIA_KBD_CTL);
        busRead("muxDspReg", busPkg::PIA_DSP_REG);
        busRead("muxDspCtl", busPkg::PIA_DSP_CTL);
        for (int i = 0; i < 8; i++)
            busRead("muxMem", hostWritten[$unsigned($random(seed)) % NUM_RANDOM]);
        parkBus();
        repeat (2) @(negedge clk_dut);

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- tb.f
+incdir+dv
src/emuPkg.sv
src/busPkg.sv
src/hostTransactor.sv
src/busDecoder.sv
src/keyboardPort.sv
src/displayPort.sv
src/embeddedMemory.sv
src/emuWrapper.sv
dv/tbEmuWrapper.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps -f tb.f \
    --top-module tbEmuWrapper -Mdir obj_dir

output=$(./obj_dir/VtbEmuWrapper)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation finished: PASS"; then
    exit 0
fi
exit 1
